//--- filelist.f
+incdir+include
hdl/event_printer_pkg.sv
hdl/event_capture.sv
hdl/bin_to_bcd.sv
hdl/record_formatter.sv
hdl/uart_tx.sv
hdl/event_printer_top.sv
sim/tb_clock_gen.sv
sim/event_printer_tb.sv

//--- Bender.yml
package:
  name: event_printer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/event_printer_pkg.sv
      - hdl/event_capture.sv
      - hdl/bin_to_bcd.sv
      - hdl/record_formatter.sv
      - hdl/uart_tx.sv
      - hdl/event_printer_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_clock_gen.sv
      - sim/event_printer_tb.sv

//--- sim/event_printer_tb.sv
`default_nettype none
`include "event_printer_defines.svh"

module event_printer_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import event_printer_pkg::*;

   localparam int LINE_LEN = `TIME_DIGITS + 1 + (`N_CH + 1) * (`PEAK_DIGITS + 1);

   logic               clk;
   logic               reset;
   logic [`DVSR_W-1:0] dvsr;
   logic               daq_pulse;
   logic [`TIME_W-1:0] evt_time;
   peak_array_t        evt_peaks;
   logic [`PEAK_W-1:0] evt_threshold;
   logic               tx;

   int                 checks;
   int                 errors;
   int                 bit_cycles;                        // Clocks per serial bit
   logic [7:0]         exp_line [LINE_LEN];               // Expected text of one record

   tb_clock_gen u_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   event_printer_top UUT (
      .clk         (clk),
      .reset       (reset),
      .i_dvsr      (dvsr),
      .i_daq_pulse (daq_pulse),
      .i_time      (evt_time),
      .i_peaks     (evt_peaks),
      .i_threshold (evt_threshold),
      .o_tx        (tx)
   );

   task automatic finish_run();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   endtask

   task automatic abort_run(input string reason);
      $display("Timeout: %s", reason);
      errors++;
      finish_run();
   endtask

   task automatic report_test(input string name, input int err0);
      $display("Test %-12s done, %0d errors", name, errors - err0);
   endtask

   // **************************************************
   // Reference model of one printed line
   // **************************************************
   task automatic build_expected(input logic [`TIME_W-1:0] t, input peak_array_t p,
                                 input logic [`PEAK_W-1:0] th);
      string hex_digits;
      int    pos;
      int    nib;
      int    value;
      hex_digits = "0123456789ABCDEF";
      pos = 0;
      for (int n = `TIME_DIGITS - 1; n >= 0; n--) begin
         nib = (t >> (4 * n)) % 16;
         exp_line[pos] = hex_digits[nib];                 // Upper case hex
         pos++;
      end
      exp_line[pos] = `ASCII_SPACE;
      pos++;
      for (int v = 0; v <= `N_CH; v++) begin
         value = (v < `N_CH) ? int'(p[v]) : int'(th);     // Threshold comes last
         for (int d = `PEAK_DIGITS - 1; d >= 0; d--) begin
            exp_line[pos] = `ASCII_ZERO + (value / (10 ** d)) % 10;
            pos++;
         end
         exp_line[pos] = (v < `N_CH) ? `ASCII_SPACE : `ASCII_NEWLINE;
         pos++;
      end
   endtask

   task automatic compare_byte(input string name, input int idx, input logic [7:0] got);
      checks++;
      if (got !== exp_line[idx]) begin
         $display("[ERROR] %s: byte %0d expected 8'h%02h actual 8'h%02h",
                  name, idx, exp_line[idx], got);
         errors++;
      end
   endtask

   // **************************************************
   // Stimulus and serial line decoder
   // **************************************************
   task automatic set_divisor(input int d);
      @(posedge clk);
      dvsr       <= d;
      bit_cycles  = `OVERSAMPLE * (d + 1);
   endtask

   task automatic drive_event(input logic [`TIME_W-1:0] t, input peak_array_t p,
                              input logic [`PEAK_W-1:0] th, input int hold);
      @(posedge clk);
      evt_time      <= t;
      evt_peaks     <= p;
      evt_threshold <= th;
      daq_pulse     <= 1'b1;
      repeat (hold) @(posedge clk);
      daq_pulse     <= 1'b0;
   endtask

   task automatic wait_start(input int limit);
      int waited;
      waited = 0;
      @(negedge clk);
      while (tx !== 1'b0 && waited < limit) begin
         @(negedge clk);
         waited++;
      end
      if (tx !== 1'b0) begin
         abort_run("no start bit arrived on the serial line");
      end
   endtask

   // Sample data bits at mid-bit, then the stop bit
   task automatic read_bits(input int first_wait, output logic [7:0] data);
      data = '0;
      repeat (first_wait) @(negedge clk);
      data[0] = tx;
      for (int b = 1; b < 8; b++) begin
         repeat (bit_cycles) @(negedge clk);
         data[b] = tx;
      end
      repeat (bit_cycles) @(negedge clk);
      checks++;
      if (tx !== 1'b1) begin
         $display("Stop bit was low where the line should be high");
         errors++;
      end
   endtask

   task automatic recv_byte(output logic [7:0] data);
      wait_start(20 * bit_cycles + 200);
      repeat (bit_cycles / 2) @(negedge clk);              // Middle of start bit
      checks++;
      if (tx !== 1'b0) begin
         $display("Start bit ended before its middle");
         errors++;
      end
      read_bits(bit_cycles, data);
   endtask

   task automatic measure_start(output int len);
      wait_start(20 * bit_cycles + 200);
      len = 0;
      while (tx === 1'b0 && len < 4 * bit_cycles) begin
         len++;
         @(negedge clk);
      end
   endtask

   task automatic receive_rest(input string name, input int first);
      logic [7:0] got;
      for (int i = first; i < LINE_LEN; i++) begin
         recv_byte(got);
         compare_byte(name, i, got);
      end
   endtask

   task automatic check_record(input string name, input logic [`TIME_W-1:0] t,
                               input peak_array_t p, input logic [`PEAK_W-1:0] th);
      build_expected(t, p, th);
      receive_rest(name, 0);
   endtask

   task automatic expect_quiet(input string name, input int cycles);
      int low_seen;
      low_seen = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (tx !== 1'b1) begin
            low_seen++;
         end
      end
      checks++;
      if (low_seen != 0) begin
         $display("%s: serial line left its idle level during a quiet window", name);
         errors++;
      end
   endtask

   // **************************************************
   // Directed tests
   // **************************************************
   task automatic test_reset_idle();
      int err0;
      int waited;
      err0   = errors;
      waited = 0;
      while (reset !== 1'b0 && waited < 20) begin
         @(negedge clk);
         waited++;
         checks++;
         if (tx !== 1'b1) begin
            $display("[ERROR] reset_idle: o_tx expected 1 actual %b", tx);
            errors++;
         end
      end
      if (reset !== 1'b0) begin
         abort_run("reset was never released");
      end
      expect_quiet("reset_idle", 200);
      report_test("reset_idle", err0);
   endtask

   task automatic test_single_record();
      int          err0;
      peak_array_t p;
      err0 = errors;
      p[0] = 12'd0;
      p[1] = 12'd4095;
      p[2] = 12'd302;
      p[3] = 12'd58;
      drive_event(16'hB7E0, p, 12'd1000, 1);
      check_record("single", 16'hB7E0, p, 12'd1000);
      expect_quiet("single", bit_cycles);                  // Stop bit runs out
      report_test("single", err0);
   endtask

   task automatic test_framing();
      int          err0;
      int          len;
      logic [7:0]  got;
      peak_array_t p;
      err0 = errors;
      p[0] = 12'd1;
      p[1] = 12'd20;
      p[2] = 12'd300;
      p[3] = 12'd4000;
      for (int k = 0; k < 2; k++) begin
         set_divisor(3 + 4 * k);                          // Divisor 3, then 7
         drive_event(16'h1C2B + k, p, 12'd77, 1);          // First char has LSB set
         build_expected(16'h1C2B + k, p, 12'd77);
         measure_start(len);
         checks++;
         if (len < bit_cycles - 1 || len > bit_cycles + 1) begin
            $display("[ERROR] framing: start bit cycles expected %0d actual %0d",
                     bit_cycles, len);
            errors++;
         end
         read_bits(bit_cycles / 2, got);
         compare_byte("framing", 0, got);
         receive_rest("framing", 1);
         expect_quiet("framing", bit_cycles);
      end
      set_divisor(1);
      report_test("framing", err0);
   endtask

   task automatic test_edge_detect();
      int          err0;
      peak_array_t p;
      err0 = errors;
      p[0] = 12'd11;
      p[1] = 12'd222;
      p[2] = 12'd3333;
      p[3] = 12'd4;
      fork
         drive_event(16'h5A5A, p, 12'd900, 50);            // Pulse held high
         check_record("edge", 16'h5A5A, p, 12'd900);
      join
      expect_quiet("edge", 2 * LINE_LEN * 10 * bit_cycles);
      report_test("edge", err0);
   endtask

   task automatic test_overflow();
      int                 err0;
      logic [`TIME_W-1:0] ov_time [8];
      peak_array_t        ov_peaks [8];
      logic [`PEAK_W-1:0] ov_thr [8];
      peak_array_t        p;
      err0 = errors;
      for (int k = 0; k < 8; k++) begin
         ov_time[k] = 16'hE000 + k * 16'h0111;
         for (int ch = 0; ch < `N_CH; ch++) begin
            ov_peaks[k][ch] = k * 500 + ch * 37;
         end
         ov_thr[k] = 12'd4000 - k * 3;
      end
      set_divisor(7);
      fork
         begin
            for (int k = 0; k < 8; k++) begin
               drive_event(ov_time[k], ov_peaks[k], ov_thr[k], 1);
               repeat (2) @(posedge clk);                 // Edges 4 cycles apart
            end
         end
         begin
            for (int k = 0; k < 1 + `FIFO_DEPTH; k++) begin
               check_record("overflow", ov_time[k], ov_peaks[k], ov_thr[k]);
               if (k == 0) begin
                  drive_event(16'hDEAD, ov_peaks[0], 12'd5, 1);   // FIFO not yet drained
               end
            end
         end
      join
      expect_quiet("overflow", 3 * bit_cycles);            // Later events were dropped
      p[0] = 12'd9;
      p[1] = 12'd99;
      p[2] = 12'd999;
      p[3] = 12'd3999;
      drive_event(16'hF00D, p, 12'd1234, 1);
      check_record("overflow", 16'hF00D, p, 12'd1234);
      expect_quiet("overflow", bit_cycles);
      set_divisor(1);
      report_test("overflow", err0);
   endtask

   task automatic test_random();
      int                 err0;
      logic [`TIME_W-1:0] t;
      peak_array_t        p;
      logic [`PEAK_W-1:0] th;
      err0 = errors;
      for (int k = 0; k < 10; k++) begin
         t = $urandom;
         for (int ch = 0; ch < `N_CH; ch++) begin
            p[ch] = $urandom % 4096;
         end
         th = $urandom % 4096;
         drive_event(t, p, th, 1);
         check_record("random", t, p, th);
      end
      expect_quiet("random", bit_cycles);
      report_test("random", err0);
   endtask

   initial begin
      checks        = 0;
      errors        = 0;
      dvsr          = 1;
      bit_cycles    = `OVERSAMPLE * 2;
      daq_pulse     = 1'b0;
      evt_time      = '0;
      evt_peaks     = '0;
      evt_threshold = '0;
      void'($urandom(32'hfe38_a79d));
      test_reset_idle();
      test_single_record();
      test_framing();
      test_edge_detect();
      test_overflow();
      test_random();
      finish_run();
   end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk   = 1'b0;
      reset = 1'b1;                                       // Held for 4 cycles
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   end

   always #50 clk = ~clk;                                 // 100 ns period

endmodule

`default_nettype wire

//--- hdl/event_printer_top.sv
`default_nettype none
`include "event_printer_defines.svh"

module event_printer_top (
   input  wire                             clk,
   input  wire                             reset,
   input  wire  [`DVSR_W-1:0]              i_dvsr,
   input  wire                             i_daq_pulse,
   input  wire  [`TIME_W-1:0]              i_time,
   input  wire  event_printer_pkg::peak_array_t i_peaks,
   input  wire  [`PEAK_W-1:0]              i_threshold,
   output logic                            o_tx
);
   import event_printer_pkg::*;

   logic               evt_valid;                         // FIFO head to formatter
   logic               evt_ready;
   logic [`TIME_W-1:0] evt_time;
   peak_array_t        evt_peaks;
   logic [`PEAK_W-1:0] evt_threshold;
   logic               byte_valid;                        // Formatter to serial line
   logic               byte_ready;
   logic [7:0]         tx_byte;

   event_capture u_event_capture (
      .clk             (clk),
      .reset           (reset),
      .i_daq_pulse     (i_daq_pulse),
      .i_time          (i_time),
      .i_peaks         (i_peaks),
      .i_threshold     (i_threshold),
      .i_evt_ready     (evt_ready),
      .o_evt_valid     (evt_valid),
      .o_evt_time      (evt_time),
      .o_evt_peaks     (evt_peaks),
      .o_evt_threshold (evt_threshold)
   );

   record_formatter u_record_formatter (
      .clk             (clk),
      .reset           (reset),
      .i_evt_valid     (evt_valid),
      .i_evt_time      (evt_time),
      .i_evt_peaks     (evt_peaks),
      .i_evt_threshold (evt_threshold),
      .o_evt_ready     (evt_ready),
      .i_byte_ready    (byte_ready),
      .o_byte_valid    (byte_valid),
      .o_byte          (tx_byte)
   );

   uart_tx u_uart_tx (
      .clk          (clk),
      .reset        (reset),
      .i_dvsr       (i_dvsr),
      .i_byte_valid (byte_valid),
      .i_byte       (tx_byte),
      .o_byte_ready (byte_ready),
      .o_tx         (o_tx)
   );

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`default_nettype none
`include "event_printer_defines.svh"

module uart_tx (
   input  wire                 clk,
   input  wire                 reset,
   input  wire  [`DVSR_W-1:0]  i_dvsr,
   input  wire                 i_byte_valid,
   input  wire  [7:0]          i_byte,
   output logic                o_byte_ready,
   output logic                o_tx
);
   import event_printer_pkg::*;

   localparam int TICK_W = $clog2(`OVERSAMPLE);

   tx_state_t           state;
   logic [`DVSR_W-1:0]  div_cnt;
   logic                tick;
   logic                bit_end;
   logic [TICK_W-1:0]   tick_cnt;
   logic [2:0]          bit_cnt;
   logic [7:0]          shreg;

   assign o_byte_ready = (state == TX_IDLE);
   assign tick         = (state != TX_IDLE) && (div_cnt == i_dvsr);
   assign bit_end      = tick && (tick_cnt == TICK_W'(`OVERSAMPLE - 1));

   // **************************************************
   // Baud tick, restarted with every frame
   // **************************************************
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         div_cnt <= '0;
      end else if (state == TX_IDLE || tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state    <= TX_IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         o_tx     <= 1'b1;                                // Line idles high
      end else begin
         if (bit_end) begin
            tick_cnt <= '0;
         end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
         end
         case (state)
            TX_IDLE: begin
               if (i_byte_valid) begin
                  o_tx     <= 1'b0;                       // Start bit
                  tick_cnt <= '0;
                  state    <= TX_START;
               end
            end
            TX_START: begin
               if (bit_end) begin
                  o_tx    <= shreg[0];
                  bit_cnt <= '0;
                  state   <= TX_DATA;
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  if (bit_cnt == 3'd7) begin
                     o_tx  <= 1'b1;                       // Stop bit
                     state <= TX_STOP;
                  end else begin
                     o_tx    <= shreg[1];
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            TX_STOP: begin
               if (bit_end) begin
                  state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == TX_IDLE && i_byte_valid) begin
         shreg <= i_byte;
      end else if (state == TX_DATA && bit_end) begin
         shreg <= shreg >> 1;                             // LSB first
      end
   end

endmodule

`default_nettype wire

//--- hdl/record_formatter.sv
`default_nettype none
`include "event_printer_defines.svh"

module record_formatter (
   input  wire                             clk,
   input  wire                             reset,
   input  wire                             i_evt_valid,
   input  wire  [`TIME_W-1:0]              i_evt_time,
   input  wire  event_printer_pkg::peak_array_t i_evt_peaks,
   input  wire  [`PEAK_W-1:0]              i_evt_threshold,
   output logic                            o_evt_ready,
   input  wire                             i_byte_ready,
   output logic                            o_byte_valid,
   output logic [7:0]                      o_byte
);
   import event_printer_pkg::*;

   localparam int IDX_W = $clog2(`N_CH + 1);

   fmt_state_t                state;
   logic [`TIME_W-1:0]        time_sh;
   peak_array_t               peaks_reg;
   logic [`PEAK_W-1:0]        thr_reg;
   logic [IDX_W-1:0]          value_idx;                  // Threshold is index N_CH
   logic [2:0]                digit_cnt;
   logic                      byte_xfer;
   logic                      conv_start;
   logic [`PEAK_W-1:0]        conv_bin;
   logic [4*`PEAK_DIGITS-1:0] conv_bcd;
   logic [4*`PEAK_DIGITS-1:0] bcd_sh;
   logic                      conv_done;
   logic [`PEAK_W-1:0]        next_value;

   function automatic logic [7:0] hex_char(input logic [3:0] nib);
      if (nib < 4'd10) begin
         return `ASCII_ZERO + {4'h0, nib};
      end
      return `ASCII_A + {4'h0, nib} - 8'd10;             // Upper case letters
   endfunction

   assign o_evt_ready = (state == IDLE);                  // Pop only between records
   assign byte_xfer   = o_byte_valid & i_byte_ready;
   assign next_value  = (value_idx < `N_CH) ? peaks_reg[value_idx] : thr_reg;

   bin_to_bcd #(
      .IN_W   (`PEAK_W),
      .DIGITS (`PEAK_DIGITS)
   ) u_bin_to_bcd (
      .clk     (clk),
      .reset   (reset),
      .i_start (conv_start),
      .i_bin   (conv_bin),
      .o_bcd   (conv_bcd),
      .o_done  (conv_done)
   );

   // **************************************************
   // Record sequencing
   // **************************************************
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         state        <= IDLE;
         o_byte_valid <= 1'b0;
         conv_start   <= 1'b0;
         value_idx    <= '0;
         digit_cnt    <= '0;
      end else begin
         conv_start <= 1'b0;
         case (state)
            IDLE: begin
               if (i_evt_valid) begin
                  state <= LOAD;
               end
            end
            LOAD: begin
               o_byte_valid <= 1'b1;                      // First hex digit
               digit_cnt    <= 3'd1;
               value_idx    <= '0;
               state        <= SEND_TIME;
            end
            SEND_TIME: begin
               if (byte_xfer) begin
                  if (digit_cnt < `TIME_DIGITS) begin
                     digit_cnt <= digit_cnt + 1'b1;
                  end else begin
                     state <= SEND_SEP;
                  end
               end
            end
            SEND_SEP: begin
               if (byte_xfer) begin
                  o_byte_valid <= 1'b0;
                  conv_start   <= 1'b1;
                  state        <= CONVERT;
               end
            end
            CONVERT: begin
               if (conv_done) begin
                  o_byte_valid <= 1'b1;
                  digit_cnt    <= 3'd1;
                  state        <= SEND_VALUE;
               end
            end
            SEND_VALUE: begin
               if (byte_xfer) begin
                  if (digit_cnt < `PEAK_DIGITS) begin
                     digit_cnt <= digit_cnt + 1'b1;
                  end else if (value_idx == IDX_W'(`N_CH)) begin
                     state <= SEND_NEWLINE;
                  end else begin
                     value_idx <= value_idx + 1'b1;
                     state     <= SEND_SEP;
                  end
               end
            end
            SEND_NEWLINE: begin
               if (byte_xfer) begin
                  o_byte_valid <= 1'b0;
                  state        <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // **************************************************
   // Event copy and byte contents
   // **************************************************
   always_ff @(posedge clk) begin
      case (state)
         IDLE: begin
            if (i_evt_valid) begin
               time_sh   <= i_evt_time;
               peaks_reg <= i_evt_peaks;
               thr_reg   <= i_evt_threshold;
            end
         end
         LOAD: begin
            o_byte  <= hex_char(time_sh[`TIME_W-1 -: 4]);
            time_sh <= time_sh << 4;
         end
         SEND_TIME: begin
            if (byte_xfer) begin
               if (digit_cnt < `TIME_DIGITS) begin
                  o_byte  <= hex_char(time_sh[`TIME_W-1 -: 4]);
                  time_sh <= time_sh << 4;
               end else begin
                  o_byte <= `ASCII_SPACE;
               end
            end
         end
         SEND_SEP: begin
            if (byte_xfer) begin
               conv_bin <= next_value;
            end
         end
         CONVERT: begin
            if (conv_done) begin
               o_byte <= `ASCII_ZERO + {4'h0, conv_bcd[4*`PEAK_DIGITS-1 -: 4]};
               bcd_sh <= conv_bcd << 4;
            end
         end
         SEND_VALUE: begin
            if (byte_xfer) begin
               if (digit_cnt < `PEAK_DIGITS) begin
                  o_byte <= `ASCII_ZERO + {4'h0, bcd_sh[4*`PEAK_DIGITS-1 -: 4]};
                  bcd_sh <= bcd_sh << 4;
               end else if (value_idx == IDX_W'(`N_CH)) begin
                  o_byte <= `ASCII_NEWLINE;               // Line ends after threshold
               end else begin
                  o_byte <= `ASCII_SPACE;
               end
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/bin_to_bcd.sv
`default_nettype none

module bin_to_bcd #(
   parameter int IN_W   = 12,
   parameter int DIGITS = 4
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  i_start,
   input  wire  [IN_W-1:0]      i_bin,
   output logic [4*DIGITS-1:0]  o_bcd,
   output logic                 o_done
);
   localparam int WORK_W = 4*DIGITS + IN_W;
   localparam int CNT_W  = $clog2(IN_W + 1);

   logic [WORK_W-1:0] work;                               // BCD digits above binary
   logic [WORK_W-1:0] work_step;
   logic [CNT_W-1:0]  steps_left;
   logic              busy;
   logic              last_step;

   // Add three to digits above four, then shift
   always_comb begin
      work_step = work;
      for (int d = 0; d < DIGITS; d++) begin
         if (work_step[IN_W + 4*d +: 4] > 4'd4) begin
            work_step[IN_W + 4*d +: 4] = work_step[IN_W + 4*d +: 4] + 4'd3;
         end
      end
      work_step = work_step << 1;
   end

   assign last_step = busy && !i_start && (steps_left == CNT_W'(1));

   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         busy       <= 1'b0;
         steps_left <= '0;
         o_done     <= 1'b0;
      end else begin
         o_done <= last_step;                             // Single cycle pulse
         if (i_start) begin
            busy       <= 1'b1;
            steps_left <= CNT_W'(IN_W);
         end else if (busy) begin
            steps_left <= steps_left - 1'b1;
            if (last_step) begin
               busy <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_start) begin
         work <= {{(4*DIGITS){1'b0}}, i_bin};
      end else if (busy) begin
         work <= work_step;
      end
      if (last_step) begin
         o_bcd <= work_step[WORK_W-1 -: 4*DIGITS];        // Held until next start
      end
   end

endmodule

`default_nettype wire

//--- hdl/event_capture.sv
`default_nettype none
`include "event_printer_defines.svh"

module event_capture (
   input  wire                             clk,
   input  wire                             reset,
   input  wire                             i_daq_pulse,
   input  wire  [`TIME_W-1:0]              i_time,
   input  wire  event_printer_pkg::peak_array_t i_peaks,
   input  wire  [`PEAK_W-1:0]              i_threshold,
   input  wire                             i_evt_ready,
   output logic                            o_evt_valid,
   output logic [`TIME_W-1:0]              o_evt_time,
   output event_printer_pkg::peak_array_t  o_evt_peaks,
   output logic [`PEAK_W-1:0]              o_evt_threshold
);
   import event_printer_pkg::*;

   logic                daq_prev;
   logic                daq_rise;
   gate_state_t         gate_state;
   logic [`FIFO_AW-1:0] wr_ptr;
   logic [`FIFO_AW-1:0] rd_ptr;
   logic [`FIFO_AW:0]   count;
   logic [`FIFO_AW:0]   count_next;
   logic                fifo_full;
   logic                fifo_empty;
   logic                wr_en;
   logic                rd_en;

   logic [`TIME_W-1:0]  time_mem [`FIFO_DEPTH];
   peak_array_t         peak_mem [`FIFO_DEPTH];
   logic [`PEAK_W-1:0]  thr_mem  [`FIFO_DEPTH];

   assign daq_rise   = i_daq_pulse & ~daq_prev;           // Rising edge only
   assign fifo_full  = (count == `FIFO_DEPTH);
   assign fifo_empty = (count == '0);
   assign wr_en      = daq_rise & (gate_state == ACCEPTING) & ~fifo_full;
   assign rd_en      = o_evt_valid & i_evt_ready;

   always_comb begin
      count_next = count;
      if (wr_en && !rd_en) begin
         count_next = count + 1'b1;
      end else if (rd_en && !wr_en) begin
         count_next = count - 1'b1;
      end
   end

   // **************************************************
   // Edge detect, pointers and write gate
   // **************************************************
   always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
         daq_prev   <= 1'b0;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         gate_state <= DRAINING;                          // Opens once seen empty
      end else begin
         daq_prev <= i_daq_pulse;
         count    <= count_next;
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;                       // Wraps at depth
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case (gate_state)
            ACCEPTING: begin
               if (count_next == `FIFO_DEPTH) begin
                  gate_state <= DRAINING;
               end
            end
            DRAINING: begin
               if (fifo_empty) begin
                  gate_state <= ACCEPTING;
               end
            end
            default: gate_state <= DRAINING;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         time_mem[wr_ptr] <= i_time;
         peak_mem[wr_ptr] <= i_peaks;
         thr_mem[wr_ptr]  <= i_threshold;
      end
   end

   // Head of the FIFO
   assign o_evt_valid     = ~fifo_empty;
   assign o_evt_time      = time_mem[rd_ptr];
   assign o_evt_peaks     = peak_mem[rd_ptr];
   assign o_evt_threshold = thr_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/event_printer_pkg.sv
`default_nettype none
`include "event_printer_defines.svh"

package event_printer_pkg;

   typedef logic [`N_CH-1:0][`PEAK_W-1:0] peak_array_t;   // One peak per channel

   typedef enum logic [2:0] {
      IDLE,
      LOAD,
      SEND_TIME,
      CONVERT,
      SEND_VALUE,
      SEND_SEP,
      SEND_NEWLINE
   } fmt_state_t;

   typedef enum logic {
      ACCEPTING,
      DRAINING                                            // Writes dropped until empty
   } gate_state_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

endpackage

`default_nettype wire

//--- include/event_printer_defines.svh
`ifndef EVENT_PRINTER_DEFINES_SVH
`define EVENT_PRINTER_DEFINES_SVH

// Event contents
`define TIME_W        16
`define N_CH          4
`define PEAK_W        12
`define PEAK_DIGITS   4
`define TIME_DIGITS   (`TIME_W / 4)

// Event FIFO
`define FIFO_DEPTH    4
`define FIFO_AW       2

// Serial line
`define DVSR_W        11
`define OVERSAMPLE    16

// Characters of a printed line
`define ASCII_SPACE   8'h20
`define ASCII_NEWLINE 8'h0a
`define ASCII_ZERO    8'h30
`define ASCII_A       8'h41

`endif
